//--- verilog.f
logic/ifetch_pkg.sv
logic/rd_chan_if.sv
logic/icache.sv
logic/boot_mem.sv
logic/perf_counters.sv
logic/ifetch_top.sv
sim/tb_clkgen.sv
sim/ifetch_tb.sv

//--- Makefile
# Verilator build and run for the instruction-fetch subsystem testbench
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ifetch_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the binary is run from the project root so program.hex is found
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- program.hex
// one 64-bit beat per line, beat i at byte address 8*i, upper word holds address bit 2 set
c0de0004c0de0000
c0de000cc0de0008
c0de0014c0de0010
c0de001cc0de0018
c0de0024c0de0020
c0de002cc0de0028
c0de0034c0de0030
c0de003cc0de0038
c0de0044c0de0040
c0de004cc0de0048
c0de0054c0de0050
c0de005cc0de0058
c0de0064c0de0060
c0de006cc0de0068
c0de0074c0de0070
c0de007cc0de0078
c0de0084c0de0080
c0de008cc0de0088
c0de0094c0de0090
c0de009cc0de0098
c0de00a4c0de00a0
c0de00acc0de00a8
c0de00b4c0de00b0
c0de00bcc0de00b8
c0de00c4c0de00c0
c0de00ccc0de00c8
c0de00d4c0de00d0
c0de00dcc0de00d8
c0de00e4c0de00e0
c0de00ecc0de00e8
c0de00f4c0de00f0
c0de00fcc0de00f8

//--- sim/ifetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * ifetch_tb: table-driven testbench for ifetch_top, with a model of
 * cache tags and counters that predicts hits, misses and data
 */
module ifetch_tb;

  localparam int n_tests      = 18;
  localparam int reset_cycles = 8;
  // a slow miss needs about 7 cycles
  localparam int cycles_per_test = 20;

  logic                          clk;
  logic                          rstn;
  logic                          arvalid;
  logic                          arready;
  logic [ifetch_pkg::addr_w-1:0] araddr;
  logic                          rvalid;
  logic                          rready;
  logic [ifetch_pkg::data_w-1:0] rdata;
  logic [ifetch_pkg::cnt_w-1:0]  hit_count;
  logic [ifetch_pkg::cnt_w-1:0]  miss_count;

  // fetch table with name, address and expected outcome
  string                         tbl_name [n_tests];
  logic [ifetch_pkg::addr_w-1:0] tbl_addr [n_tests];
  logic                          tbl_hit  [n_tests];

  // private copy of the boot image
  logic [ifetch_pkg::data_w-1:0] image [ifetch_pkg::mem_words];

  // cache model
  logic                          mdl_valid [ifetch_pkg::set_n];
  logic [ifetch_pkg::tag_w-1:0]  mdl_tag   [ifetch_pkg::set_n];
  int                            exp_hits;
  int                            exp_misses;

  tb_clkgen tb_clkgen_i (
    .clk  (clk),
    .rstn (rstn)
  );

  ifetch_top ifetch_top_i (
    .clk         (clk),
    .rstn        (rstn),
    .ifu_arvalid (arvalid),
    .ifu_arready (arready),
    .ifu_araddr  (araddr),
    .ifu_rvalid  (rvalid),
    .ifu_rready  (rready),
    .ifu_rdata   (rdata),
    .hit_count   (hit_count),
    .miss_count  (miss_count)
  );

  task automatic set_entry(input int i, input string name,
                           input logic [31:0] addr, input logic hit);
    tbl_name[i] = name;
    tbl_addr[i] = addr;
    tbl_hit[i]  = hit;
  endtask

  task automatic fill_table();
    set_entry(0,  "sram_first",       32'h0000_0010, 1'b0);
    set_entry(1,  "sram_repeat",      32'h0000_0010, 1'b0);
    set_entry(2,  "sram_region2",     32'h2000_0024, 1'b0);
    set_entry(3,  "sram_region2_rep", 32'h2000_0024, 1'b0);
    set_entry(4,  "flash_first",      32'h3000_0008, 1'b0);
    set_entry(5,  "flash_repeat",     32'h3000_0008, 1'b1);
    set_entry(6,  "flash_upper",      32'h3000_000c, 1'b0);
    set_entry(7,  "flash_upper_rep",  32'h3000_000c, 1'b1);
    // sram in the set of flash_first must not evict it
    set_entry(8,  "sram_same_index",  32'h1000_0008, 1'b0);
    set_entry(9,  "flash_kept",       32'h3000_0008, 1'b1);
    set_entry(10, "sdram_first",      32'h8000_0134, 1'b0);
    set_entry(11, "sdram_repeat",     32'h8000_0134, 1'b1);
    // set 4 with two tags fighting over it
    set_entry(12, "evict_a",          32'h4000_0050, 1'b0);
    set_entry(13, "evict_b",          32'h5000_0050, 1'b0);
    set_entry(14, "evict_a_again",    32'h4000_0050, 1'b0);
    set_entry(15, "evict_a_hit",      32'h4000_0050, 1'b1);
    set_entry(16, "sdram_top",        32'hf000_00fc, 1'b0);
    set_entry(17, "sdram_top_rep",    32'hf000_00fc, 1'b1);
  endtask

  // flash and sdram only
  function automatic logic is_cacheable(input logic [ifetch_pkg::addr_w-1:0] a);
    return a[ifetch_pkg::addr_w-1 -: 4] >= ifetch_pkg::cacheable_region;
  endfunction

  // 32-bit word picked from the beat by address bit 2
  function automatic logic [31:0] expect_word(input logic [ifetch_pkg::addr_w-1:0] a);
    logic [ifetch_pkg::data_w-1:0] beat;
    beat = image[a[7:3]];
    return a[2] ? beat[63:32] : beat[31:0];
  endfunction

  task automatic check_value(input string name, input string what,
                             input logic [63:0] exp_val, input logic [63:0] act_val);
    assert (act_val === exp_val) else begin
      $display("ERR %s %s: expected %h, actual %h", name, what, exp_val, act_val);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_counters(input string name);
    check_value(name, "hit_count", 64'(exp_hits), 64'(hit_count));
    check_value(name, "miss_count", 64'(exp_misses), 64'(miss_count));
  endtask

  // starts and ends on a falling edge
  task automatic fetch_one(input int t);
    logic [ifetch_pkg::addr_w-1:0]  addr;
    logic [ifetch_pkg::index_w-1:0] idx;
    logic [ifetch_pkg::tag_w-1:0]   tag;
    logic [31:0]                    word;
    logic                           predicted;
    int                             lat;
    addr      = tbl_addr[t];
    idx       = addr[ifetch_pkg::offset_w +: ifetch_pkg::index_w];
    tag       = addr[ifetch_pkg::addr_w-1 -: ifetch_pkg::tag_w];
    word      = expect_word(addr);
    predicted = mdl_valid[idx] && (mdl_tag[idx] == tag);
    assert (predicted == tbl_hit[t]) else begin
      $display("table entry %s disagrees with the cache model on hit or miss", tbl_name[t]);
      $display("Simulation failed");
      $fatal(1, "bad table");
    end
    arvalid = 1'b1;
    araddr  = addr;
    while (!arready) begin
      @(negedge clk);
    end
    // accepted on the rising edge in between
    @(negedge clk);
    arvalid = 1'b0;
    lat     = 1;
    while (!rvalid) begin
      @(negedge clk);
      lat++;
    end
    if (predicted) begin
      check_value(tbl_name[t], "hit latency", 64'(1), 64'(lat));
      check_value(tbl_name[t], "rdata", {word, word}, rdata);
      exp_hits++;
    end else begin
      check_value(tbl_name[t], "rdata half", 64'(word),
                  64'(addr[2] ? rdata[63:32] : rdata[31:0]));
      exp_misses++;
      if (is_cacheable(addr)) begin
        mdl_valid[idx] = 1'b1;
        mdl_tag[idx]   = tag;
      end
    end
    // counters move one cycle after the response
    @(negedge clk);
    check_counters(tbl_name[t]);
  endtask

  initial begin
    arvalid    = 1'b0;
    araddr     = '0;
    rready     = 1'b1;
    exp_hits   = 0;
    exp_misses = 0;
    for (int i = 0; i < ifetch_pkg::set_n; i++) begin
      mdl_valid[i] = 1'b0;
      mdl_tag[i]   = '0;
    end
    fill_table();
    $readmemh("program.hex", image);
    wait (rstn === 1'b1);
    @(negedge clk);
    check_value("reset", "arready", 64'(1), 64'(arready));
    check_value("reset", "rvalid", 64'(0), 64'(rvalid));
    check_counters("reset");
    for (int t = 0; t < n_tests; t++) begin
      fetch_one(t);
    end
    // totals over the whole table
    check_counters("totals");
    $display("Simulation passed");
    $finish;
  end

  // watchdog
  initial begin
    repeat (n_tests * cycles_per_test + reset_cycles) @(posedge clk);
    $display("timeout, the fetch table did not complete in time");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- sim/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * tb_clkgen: 10 ns clock, active-low reset held for 8 cycles
 */
module tb_clkgen (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // release on a falling edge, clear of the sampling edge
  initial begin
    rstn = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

`default_nettype wire

//--- logic/ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * ifetch_top: instruction-fetch memory subsystem, icache in front of
 * boot_mem, with hit and miss counters on the side
 */
module ifetch_top (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          ifu_arvalid,
  output logic                          ifu_arready,
  input  logic [ifetch_pkg::addr_w-1:0] ifu_araddr,
  output logic                          ifu_rvalid,
  input  logic                          ifu_rready,
  output logic [ifetch_pkg::data_w-1:0] ifu_rdata,
  output logic [ifetch_pkg::cnt_w-1:0]  hit_count,
  output logic [ifetch_pkg::cnt_w-1:0]  miss_count
);

  ifetch_pkg::perf_evt_e evt;

  // fetch unit to cache
  rd_chan_if ifu_ch ();
  // cache to memory
  rd_chan_if mem_ch ();

  assign ifu_ch.arvalid = ifu_arvalid;
  assign ifu_ch.araddr  = ifu_araddr;
  // no size port on the fetch side, always a word
  assign ifu_ch.arsize  = ifetch_pkg::size_word;
  assign ifu_ch.rready  = ifu_rready;
  assign ifu_arready    = ifu_ch.arready;
  assign ifu_rvalid     = ifu_ch.rvalid;
  assign ifu_rdata      = ifu_ch.rdata;

  icache icache_i (
    .clk  (clk),
    .rstn (rstn),
    .ifu  (ifu_ch.slave),
    .mem  (mem_ch.master),
    .evt  (evt)
  );

  boot_mem boot_mem_i (
    .clk  (clk),
    .rstn (rstn),
    .bus  (mem_ch.slave)
  );

  perf_counters perf_counters_i (
    .clk        (clk),
    .rstn       (rstn),
    .evt        (evt),
    .hit_count  (hit_count),
    .miss_count (miss_count)
  );

endmodule

`default_nettype wire

//--- logic/perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * perf_counters: saturating hit and miss counters fed by the
 * cache event pulse
 */
module perf_counters (
  input  logic                         clk,
  input  logic                         rstn,
  input  ifetch_pkg::perf_evt_e        evt,
  output logic [ifetch_pkg::cnt_w-1:0] hit_count,
  output logic [ifetch_pkg::cnt_w-1:0] miss_count
);

  logic hit_sat;
  logic miss_sat;

  // stick at all ones instead of wrapping
  assign hit_sat  = &hit_count;
  assign miss_sat = &miss_count;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      hit_count  <= '0;
      miss_count <= '0;
    end else begin
      case (evt)
        ifetch_pkg::evt_hit: begin
          if (!hit_sat) begin
            hit_count <= hit_count + 1'b1;
          end
        end
        ifetch_pkg::evt_miss: begin
          if (!miss_sat) begin
            miss_count <= miss_count + 1'b1;
          end
        end
        default: begin
          // evt_none, nothing to count
        end
      endcase
    end
  end

  // X on evt would silently skip counts
  a_evt_known: assert property (
    @(posedge clk) disable iff (!rstn)
    !$isunknown(evt)
  );

endmodule

`default_nettype wire

//--- logic/boot_mem.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * boot_mem: 64-bit read-only memory model with per-region wait states,
 * one shared array aliased across sram, flash and sdram
 */
module boot_mem (
  input logic      clk,
  input logic      rstn,
  rd_chan_if.slave bus
);

  // beat index comes from address bits 7..3
  localparam int idx_w = $clog2(ifetch_pkg::mem_words);

  ifetch_pkg::mem_state_e              state;
  logic [ifetch_pkg::wait_w-1:0]       wait_cnt;
  logic [ifetch_pkg::data_w-1:0]       mem_array [ifetch_pkg::mem_words];
  logic [idx_w-1:0]                    word_q;
  logic                                slow_region;
  logic                                ar_hs;

  // image shared with the testbench
  initial begin
    $readmemh("program.hex", mem_array);
  end

  assign ar_hs = bus.arvalid & bus.arready;

  // flash and sdram sit at nibble 3 and up
  assign slow_region = bus.araddr[ifetch_pkg::addr_w-1 -: 4] >= ifetch_pkg::cacheable_region;

  // one request at a time
  assign bus.arready = (state == ifetch_pkg::mem_idle);
  assign bus.rvalid  = (state == ifetch_pkg::mem_resp);
  assign bus.rdata   = mem_array[word_q];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= ifetch_pkg::mem_idle;
      wait_cnt <= '0;
    end else begin
      case (state)
        ifetch_pkg::mem_idle: begin
          if (ar_hs) begin
            state <= ifetch_pkg::mem_wait;
            // counts down to zero, so load wait minus one
            if (slow_region) begin
              wait_cnt <= ifetch_pkg::slow_wait - 1'b1;
            end else begin
              wait_cnt <= ifetch_pkg::fast_wait - 1'b1;
            end
          end
        end
        ifetch_pkg::mem_wait: begin
          if (wait_cnt == '0) begin
            state <= ifetch_pkg::mem_resp;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        ifetch_pkg::mem_resp: begin
          // single data beat
          if (bus.rready) begin
            state <= ifetch_pkg::mem_idle;
          end
        end
        default: begin
          state <= ifetch_pkg::mem_idle;
        end
      endcase
    end
  end

  // word index of the accepted request
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      word_q <= bus.araddr[3 +: idx_w];
    end
  end

  // requester must ask for single words only
  a_word_size: assert property (
    @(posedge clk) disable iff (!rstn)
    ar_hs |-> (bus.arsize == ifetch_pkg::size_word)
  );

endmodule

`default_nettype wire

//--- logic/icache.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * icache: direct-mapped instruction cache, 16 sets of one word
 * hits answer the next cycle, misses go out on the memory channel
 * and pass back as is; only flash/sdram lines are filled
 */
module icache (
  input  logic                  clk,
  input  logic                  rstn,
  rd_chan_if.slave              ifu,
  rd_chan_if.master             mem,
  output ifetch_pkg::perf_evt_e evt
);

  // line arrays
  logic                              line_valid [ifetch_pkg::set_n];
  logic [ifetch_pkg::tag_w-1:0]      line_tag   [ifetch_pkg::set_n];
  logic [ifetch_pkg::line_w-1:0]     line_data  [ifetch_pkg::set_n];

  logic                              ar_hs;
  logic                              mem_rsp;
  logic [ifetch_pkg::addr_w-1:0]     addr_q;
  logic [ifetch_pkg::addr_w-1:0]     addr;
  logic                              cacheable;
  logic [ifetch_pkg::index_w-1:0]    index;
  logic [ifetch_pkg::tag_w-1:0]      tag;
  logic                              cache_hit;
  logic                              hit_pending;
  logic [ifetch_pkg::line_w-1:0]     hit_data;
  logic [ifetch_pkg::line_w-1:0]     fill_word;

  assign ar_hs   = ifu.arvalid & ifu.arready;
  assign mem_rsp = mem.rvalid & mem.rready;

  // live address while accepting, held address while a miss runs
  assign addr = ar_hs ? ifu.araddr : addr_q;

  // sram below region 3 is fast enough uncached
  assign cacheable = addr[ifetch_pkg::addr_w-1 -: 4] >= ifetch_pkg::cacheable_region;
  assign index     = addr[ifetch_pkg::offset_w +: ifetch_pkg::index_w];
  assign tag       = addr[ifetch_pkg::addr_w-1 -: ifetch_pkg::tag_w];

  // tag holds the region nibble, so sram can never match
  assign cache_hit = line_valid[index] && (line_tag[index] == tag);

  // forward only on the accepting cycle of a miss
  assign mem.arvalid = ar_hs & ~cache_hit;
  assign mem.araddr  = addr;
  assign mem.arsize  = ifetch_pkg::size_word;
  assign mem.rready  = 1'b1;

  // hit reply from the latched word, miss reply straight from memory
  assign ifu.rvalid = hit_pending | mem.rvalid;
  assign ifu.rdata  = hit_pending ? {2{hit_data}} : mem.rdata;

  // pick the word that addr[2] points at inside the 64-bit beat
  assign fill_word = addr[2] ? mem.rdata[ifetch_pkg::data_w-1 -: ifetch_pkg::line_w]
                             : mem.rdata[ifetch_pkg::line_w-1:0];

  // one event per completed fetch response
  always_comb begin
    evt = ifetch_pkg::evt_none;
    if (ifu.rvalid && ifu.rready) begin
      evt = hit_pending ? ifetch_pkg::evt_hit : ifetch_pkg::evt_miss;
    end
  end

  // control state
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ifu.arready <= 1'b1;
      hit_pending <= 1'b0;
      for (int i = 0; i < ifetch_pkg::set_n; i++) begin
        line_valid[i] <= 1'b0;
      end
    end else begin
      // fetch side always takes the reply, so a hit lives one cycle
      hit_pending <= ar_hs & cache_hit;

      // stall new fetches until memory answers the miss
      if (ar_hs && !cache_hit) begin
        ifu.arready <= 1'b0;
      end else if (mem_rsp) begin
        ifu.arready <= 1'b1;
      end

      if (mem_rsp && cacheable) begin
        line_valid[index] <= 1'b1;
      end
    end
  end

  // address, hit word and line payload
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      addr_q   <= ifu.araddr;
      hit_data <= line_data[index];
    end
    if (mem_rsp && cacheable) begin
      line_tag[index]  <= tag;
      line_data[index] <= fill_word;
    end
  end

  // no response back-pressure on the fetch side
  a_rready_held: assert property (
    @(posedge clk) disable iff (!rstn)
    ifu.rvalid |-> ifu.rready
  );

  // an acceptance finds memory idle, so no miss is still in flight
  a_no_accept_in_miss: assert property (
    @(posedge clk) disable iff (!rstn)
    ar_hs |-> mem.arready
  );

endmodule

`default_nettype wire

//--- logic/rd_chan_if.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * rd_chan_if: read address and read data channel bundle
 * master issues addresses, slave answers with data
 */
interface rd_chan_if;

  // address channel
  logic                           arvalid;
  logic                           arready;
  logic [ifetch_pkg::addr_w-1:0]  araddr;
  logic [2:0]                     arsize;

  // data channel, no error response
  logic                           rvalid;
  logic                           rready;
  logic [ifetch_pkg::data_w-1:0]  rdata;

  modport master (
    output arvalid, araddr, arsize, rready,
    input  arready, rvalid, rdata
  );

  modport slave (
    input  arvalid, araddr, arsize, rready,
    output arready, rvalid, rdata
  );

endinterface

`default_nettype wire

//--- logic/ifetch_pkg.sv
`default_nettype none

/*
 * ifetch_pkg: shared geometry, memory timing, counter width and
 * enum types for the instruction-fetch memory subsystem
 */
package ifetch_pkg;

  // bus widths
  localparam int addr_w = 32;
  // two instruction words per beat
  localparam int data_w = 64;

  // cache geometry, direct mapped
  localparam int offset_w = 2;
  localparam int index_w  = 4;
  localparam int set_n    = 1 << index_w;
  localparam int tag_w    = addr_w - offset_w - index_w;
  // one word per line
  localparam int line_w   = 8 << offset_w;

  // top nibble 3 and up: flash, sdram
  localparam logic [3:0] cacheable_region = 4'h3;

  // memory model timing
  localparam int wait_w = 3;
  localparam logic [wait_w-1:0] fast_wait = 3'd1;
  localparam logic [wait_w-1:0] slow_wait = 3'd4;
  localparam int mem_words = 32;

  // axi encoding of a 4 byte transfer
  localparam logic [2:0] size_word = 3'b010;

  // perf counters
  localparam int cnt_w = 16;

  typedef enum logic [1:0] {
    mem_idle,
    mem_wait,
    mem_resp
  } mem_state_e;

  typedef enum logic [1:0] {
    evt_none,
    evt_hit,
    evt_miss
  } perf_evt_e;

endpackage

`default_nettype wire
